// File: include/xbar_cfg.svh
`ifndef XBAR_CFG_SVH
`define XBAR_CFG_SVH

// beat payload width
`define XBAR_DATA_W 32

// ingress and egress stream counts
`define XBAR_NUM_IN 3
`define XBAR_NUM_OUT 2

`endif

// File: hw/xbar_pkg.sv
`default_nettype none

`include "xbar_cfg.svh"

package xbar_pkg;

    // payload of one beat
    typedef logic [`XBAR_DATA_W-1:0] data_t;

    typedef logic [$clog2(`XBAR_NUM_IN)-1:0] src_t; // ingress index

    // beat as it moves through slices and switch
    typedef struct packed {
        data_t data;
        src_t  src;
    } beat_t;

    typedef logic [`XBAR_NUM_IN-1:0] grant_t; // one-hot or zero for none

endpackage

`default_nettype wire

// File: hw/stream_slice.sv
`default_nettype none

module stream_slice (
    input  wire                   aclk,
    input  wire                   aresetn,
    input  wire xbar_pkg::beat_t  in_beat,
    input  wire                   in_valid,
    output logic                  in_ready,
    output xbar_pkg::beat_t       out_beat,
    output logic                  out_valid,
    input  wire                   out_ready
);
    import xbar_pkg::*;

    typedef enum logic [1:0] {
        st_empty,
        st_one,
        st_full
    } fill_t;

    fill_t state;
    fill_t state_nxt;
    beat_t main_q;
    beat_t spill_q;
    logic  ready_q;
    logic  push;
    logic  pop;
    logic  load_main;
    logic  load_spill;
    logic  from_spill;

    assign push = in_valid && ready_q;
    assign pop  = out_valid && out_ready;

    assign load_main  = push && ((state == st_empty) || ((state == st_one) && pop));
    assign load_spill = push && (state == st_one) && !pop; // downstream stalled
    assign from_spill = pop && (state == st_full);

    always_comb begin
        state_nxt = state;
        case (state)
            st_empty: begin
                if (push) begin
                    state_nxt = st_one;
                end
            end
            st_one: begin
                if (push && !pop) begin
                    state_nxt = st_full;
                end else if (!push && pop) begin
                    state_nxt = st_empty;
                end
            end
            st_full: begin
                if (pop) begin
                    state_nxt = st_one;
                end
            end
            default: state_nxt = st_empty;
        endcase
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state   <= st_empty;
            ready_q <= 1'b1;
        end else begin
            state   <= state_nxt;
            ready_q <= (state_nxt != st_full); // registered ready
        end
    end

    always_ff @(posedge aclk) begin
        if (from_spill) begin
            main_q <= spill_q;
        end else if (load_main) begin
            main_q <= in_beat;
        end
        if (load_spill) begin
            spill_q <= in_beat;
        end
    end

    assign in_ready  = ready_q;
    assign out_valid = (state != st_empty);
    assign out_beat  = main_q;

    a_no_write_full: assert property (@(posedge aclk) disable iff (!aresetn)
        (state == st_full) |-> !push)
        else $error("stream_slice: beat written while full");

endmodule

`default_nettype wire

// File: hw/rr_grant.sv
`default_nettype none

`include "xbar_cfg.svh"

module rr_grant (
    input  wire                       aclk,
    input  wire                       aresetn,
    input  wire  [`XBAR_NUM_IN-1:0]   req,
    input  wire  [`XBAR_NUM_OUT-1:0]  free,
    output xbar_pkg::grant_t          grant_0,
    output xbar_pkg::grant_t          grant_1
);
    import xbar_pkg::*;

    src_t ptr;
    src_t cand;
    src_t first_idx;
    src_t second_idx;
    src_t last_idx;
    logic first_hit;
    logic second_hit;
    logic use_first;
    logic use_second;

    function automatic src_t next_idx(src_t idx);
        return (idx == src_t'(`XBAR_NUM_IN - 1)) ? src_t'(0) : src_t'(idx + 1'b1);
    endfunction

    // scan requests in rotation starting at the pointer
    always_comb begin
        cand       = ptr;
        first_hit  = 1'b0;
        second_hit = 1'b0;
        first_idx  = '0;
        second_idx = '0;
        for (int k = 0; k < `XBAR_NUM_IN; k++) begin
            if (req[cand] && !first_hit) begin
                first_hit = 1'b1;
                first_idx = cand;
            end else if (req[cand] && !second_hit) begin
                second_hit = 1'b1;
                second_idx = cand;
            end
            cand = next_idx(cand);
        end
    end

    assign use_first  = first_hit && (|free);
    assign use_second = second_hit && (&free); // only with both outputs free

    // first pick goes to the lowest free output
    assign grant_0 = (use_first && free[0]) ? grant_t'(grant_t'(1) << first_idx) : '0;
    assign grant_1 = use_second ? grant_t'(grant_t'(1) << second_idx) :
                     (use_first && !free[0]) ? grant_t'(grant_t'(1) << first_idx) : '0;

    assign last_idx = use_second ? second_idx : first_idx;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            ptr <= '0;
        end else if (use_first) begin
            ptr <= next_idx(last_idx); // one past last granted
        end
    end

    a_disjoint: assert property (@(posedge aclk) disable iff (!aresetn)
        (grant_0 & grant_1) == '0)
        else $error("rr_grant: input granted to both outputs");

    a_requested: assert property (@(posedge aclk) disable iff (!aresetn)
        ((grant_0 | grant_1) & ~req) == '0)
        else $error("rr_grant: grant to an idle input");

    a_free_only: assert property (@(posedge aclk) disable iff (!aresetn)
        ((|grant_0) |-> free[0]) and ((|grant_1) |-> free[1]))
        else $error("rr_grant: grant to a busy output");

endmodule

`default_nettype wire

// File: hw/xbar_switch.sv
`default_nettype none

`include "xbar_cfg.svh"

module xbar_switch (
    input  wire                       aclk,
    input  wire                       aresetn,
    input  wire xbar_pkg::beat_t      in_beat_0,
    input  wire xbar_pkg::beat_t      in_beat_1,
    input  wire xbar_pkg::beat_t      in_beat_2,
    input  wire  [`XBAR_NUM_IN-1:0]   in_valid,
    output logic [`XBAR_NUM_IN-1:0]   in_ready,
    output xbar_pkg::beat_t           out_beat_0,
    output xbar_pkg::beat_t           out_beat_1,
    output logic [`XBAR_NUM_OUT-1:0]  out_valid,
    input  wire  [`XBAR_NUM_OUT-1:0]  out_ready
);
    import xbar_pkg::*;

    beat_t  in_beats [`XBAR_NUM_IN];
    grant_t grant_0;
    grant_t grant_1;

    // one-hot select of the granted input beat
    function automatic beat_t pick(grant_t grant, beat_t beats [`XBAR_NUM_IN]);
        beat_t sel;
        sel = '0;
        for (int i = 0; i < `XBAR_NUM_IN; i++) begin
            if (grant[i]) begin
                sel = beats[i];
            end
        end
        return sel;
    endfunction

    assign in_beats[0] = in_beat_0;
    assign in_beats[1] = in_beat_1;
    assign in_beats[2] = in_beat_2;

    rr_grant i_rr_grant (
        .aclk    (aclk),
        .aresetn (aresetn),
        .req     (in_valid),
        .free    (out_ready),
        .grant_0 (grant_0),
        .grant_1 (grant_1)
    );

    assign out_beat_0 = pick(grant_0, in_beats);
    assign out_beat_1 = pick(grant_1, in_beats);

    assign out_valid = {(|grant_1), (|grant_0)};
    assign in_ready  = grant_0 | grant_1; // each granted beat leaves once

endmodule

`default_nettype wire

// File: hw/xbar_top.sv
`default_nettype none

`include "xbar_cfg.svh"

module xbar_top (
    input  wire                       aclk,
    input  wire                       aresetn,
    input  wire xbar_pkg::data_t      s_0_tdata,
    input  wire xbar_pkg::data_t      s_1_tdata,
    input  wire xbar_pkg::data_t      s_2_tdata,
    input  wire  [`XBAR_NUM_IN-1:0]   s_tvalid,
    output wire  [`XBAR_NUM_IN-1:0]   s_tready,
    output xbar_pkg::data_t           m_0_tdata,
    output xbar_pkg::data_t           m_1_tdata,
    output xbar_pkg::src_t            m_0_tsrc,
    output xbar_pkg::src_t            m_1_tsrc,
    output wire  [`XBAR_NUM_OUT-1:0]  m_tvalid,
    input  wire  [`XBAR_NUM_OUT-1:0]  m_tready
);
    import xbar_pkg::*;

    wire data_t s_tdata [`XBAR_NUM_IN];
    wire beat_t in_beat [`XBAR_NUM_IN];
    wire beat_t sw_beat [`XBAR_NUM_IN];
    wire [`XBAR_NUM_IN-1:0] sw_valid;
    wire [`XBAR_NUM_IN-1:0] sw_ready;
    wire beat_t mo_beat [`XBAR_NUM_OUT];
    wire [`XBAR_NUM_OUT-1:0] mo_valid;
    wire [`XBAR_NUM_OUT-1:0] mo_ready;
    wire beat_t m_beat [`XBAR_NUM_OUT];

    assign s_tdata[0] = s_0_tdata;
    assign s_tdata[1] = s_1_tdata;
    assign s_tdata[2] = s_2_tdata;

    for (genvar i = 0; i < `XBAR_NUM_IN; i++) begin : g_in
        assign in_beat[i] = '{data: s_tdata[i], src: src_t'(i)}; // tag with ingress index

        stream_slice i_in_slice (
            .aclk      (aclk),
            .aresetn   (aresetn),
            .in_beat   (in_beat[i]),
            .in_valid  (s_tvalid[i]),
            .in_ready  (s_tready[i]),
            .out_beat  (sw_beat[i]),
            .out_valid (sw_valid[i]),
            .out_ready (sw_ready[i])
        );
    end

    xbar_switch i_xbar_switch (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .in_beat_0  (sw_beat[0]),
        .in_beat_1  (sw_beat[1]),
        .in_beat_2  (sw_beat[2]),
        .in_valid   (sw_valid),
        .in_ready   (sw_ready),
        .out_beat_0 (mo_beat[0]),
        .out_beat_1 (mo_beat[1]),
        .out_valid  (mo_valid),
        .out_ready  (mo_ready)
    );

    for (genvar j = 0; j < `XBAR_NUM_OUT; j++) begin : g_out
        stream_slice i_out_slice (
            .aclk      (aclk),
            .aresetn   (aresetn),
            .in_beat   (mo_beat[j]),
            .in_valid  (mo_valid[j]),
            .in_ready  (mo_ready[j]),
            .out_beat  (m_beat[j]),
            .out_valid (m_tvalid[j]),
            .out_ready (m_tready[j])
        );
    end

    assign m_0_tdata = m_beat[0].data;
    assign m_0_tsrc  = m_beat[0].src;
    assign m_1_tdata = m_beat[1].data;
    assign m_1_tsrc  = m_beat[1].src;

endmodule

`default_nettype wire

// File: verification/tb_xbar_top.sv
`default_nettype none

module tb_xbar_top;
    timeunit 1ns;
    timeprecision 1ps;
    import xbar_pkg::*;

    logic       aclk = 1'b0;
    logic       aresetn;
    data_t      s_tdata [3];
    logic [2:0] s_tvalid;
    logic [2:0] s_tready;
    data_t      m_0_tdata;
    data_t      m_1_tdata;
    src_t       m_0_tsrc;
    src_t       m_1_tsrc;
    logic [1:0] m_tvalid;
    logic [1:0] m_tready;

    int         errors;
    int         next_seq [3]; // also the sent count
    int         cap_seq [3];
    int         rcv_cnt [3];
    int         via1_cnt [3];
    bit         seen [3][512];
    logic [2:0] in_fire;
    int         valid_pct;
    int         ready_pct [2];
    bit         fair_on;

    always #20 aclk = ~aclk;

    xbar_top i_dut (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .s_0_tdata (s_tdata[0]),
        .s_1_tdata (s_tdata[1]),
        .s_2_tdata (s_tdata[2]),
        .s_tvalid  (s_tvalid),
        .s_tready  (s_tready),
        .m_0_tdata (m_0_tdata),
        .m_1_tdata (m_1_tdata),
        .m_0_tsrc  (m_0_tsrc),
        .m_1_tsrc  (m_1_tsrc),
        .m_tvalid  (m_tvalid),
        .m_tready  (m_tready)
    );

    function automatic void note_fail(string msg);
        $display("FAIL t=%0t %s", $time, msg);
        errors++;
    endfunction

    function automatic int total_sent();
        return next_seq[0] + next_seq[1] + next_seq[2];
    endfunction

    function automatic int total_rcv();
        return rcv_cnt[0] + rcv_cnt[1] + rcv_cnt[2];
    endfunction

    a_reset_idle: assert property (@(posedge aclk) !aresetn |-> m_tvalid == 2'b00)
        else note_fail("m_tvalid high during reset");
    a_reset_exit: assert property (@(posedge aclk)
        $rose(aresetn) |-> (m_tvalid == 2'b00 && s_tready == 3'b111))
        else note_fail("wrong m_tvalid or s_tready in first cycle after reset");
    a_tag_0: assert property (@(posedge aclk) disable iff (!aresetn)
        m_tvalid[0] |-> m_0_tsrc == m_0_tdata[31:30])
        else note_fail("output 0 tag does not match data source bits");
    a_tag_1: assert property (@(posedge aclk) disable iff (!aresetn)
        m_tvalid[1] |-> m_1_tsrc == m_1_tdata[31:30])
        else note_fail("output 1 tag does not match data source bits");
    a_hold_0: assert property (@(posedge aclk) disable iff (!aresetn)
        m_tvalid[0] && !m_tready[0] |=> m_tvalid[0] && $stable(m_0_tdata) && $stable(m_0_tsrc))
        else note_fail("output 0 beat changed while stalled");
    a_hold_1: assert property (@(posedge aclk) disable iff (!aresetn)
        m_tvalid[1] && !m_tready[1] |=> m_tvalid[1] && $stable(m_1_tdata) && $stable(m_1_tsrc))
        else note_fail("output 1 beat changed while stalled");

    for (genvar i = 0; i < 3; i++) begin : g_fair
        a_fair: assert property (@(posedge aclk) disable iff (!fair_on)
            s_tready[i] || $past(s_tready[i]) || $past(s_tready[i], 2))
            else note_fail($sformatf("s_tready[%0d] low for more than 2 cycles", i));
    end

    // scoreboard entry for a beat that leaves on the next rising edge
    task automatic record(int j, data_t d);
        int s;
        int q;
        s = int'(d[31:30]);
        q = int'(d[29:0]);
        assert (s < 3) else note_fail($sformatf("beat with bad source %0d", s));
        if (s < 3) begin
            assert (q < next_seq[s])
                else note_fail($sformatf("input %0d beat %0d never sent", s, q));
            assert (!seen[s][q % 512])
                else note_fail($sformatf("input %0d beat %0d received twice", s, q));
            seen[s][q % 512] = 1'b1;
            rcv_cnt[s]++;
            if (j == 1) begin
                via1_cnt[s]++;
            end
        end
    endtask

    // drive on the falling edge and note what fires at the next rising edge
    task automatic step();
        @(negedge aclk);
        for (int i = 0; i < 3; i++) begin
            if (in_fire[i]) s_tvalid[i] = 1'b0;
            if (!s_tvalid[i] && next_seq[i] < cap_seq[i] && ($urandom % 100) < valid_pct) begin
                s_tvalid[i] = 1'b1;
                s_tdata[i]  = {src_t'(i), 30'(next_seq[i])}; // source in the top bits
            end
        end
        for (int j = 0; j < 2; j++) begin
            m_tready[j] = ($urandom % 100) < ready_pct[j];
        end
        if (m_tvalid[0] && m_tready[0]) record(0, m_0_tdata);
        if (m_tvalid[1] && m_tready[1]) record(1, m_1_tdata);
        for (int i = 0; i < 3; i++) begin
            in_fire[i] = s_tvalid[i] && s_tready[i];
            if (in_fire[i]) next_seq[i]++;
        end
    endtask

    function automatic bit is_done(int backlog);
        bit ok;
        ok = (s_tvalid == 3'b000);
        for (int i = 0; i < 3; i++) begin
            if (next_seq[i] < cap_seq[i]) begin
                ok = 1'b0;
            end
        end
        return ok && (total_sent() - total_rcv() <= backlog);
    endfunction

    task automatic wait_done(int backlog, int limit, string what);
        int n;
        n = 0;
        while (!is_done(backlog) && n < limit) begin
            step();
            n++;
        end
        if (!is_done(backlog)) begin
            $display("timeout: %s was not reached within %0d cycles", what, limit);
            errors++;
        end
    endtask

    initial begin
        errors    = 0;
        aresetn   = 1'b0;
        s_tvalid  = 3'b000;
        m_tready  = 2'b00;
        in_fire   = 3'b000;
        valid_pct = 0;
        fair_on   = 1'b0;
        ready_pct = '{0, 0};
        for (int i = 0; i < 3; i++) begin
            s_tdata[i]  = '0;
            next_seq[i] = 0;
            cap_seq[i]  = 0;
            rcv_cnt[i]  = 0;
            via1_cnt[i] = 0;
        end
        void'($urandom(32'hf1d6));
        repeat (10) @(negedge aclk);
        aresetn = 1'b1;
        repeat (3) step();
        $display("test reset_state done, errors %0d", errors);

        foreach (cap_seq[i]) cap_seq[i] = 200;
        valid_pct = 60;
        ready_pct = '{55, 70};
        wait_done(0, 4000, "delivery of 200 beats per input");
        for (int i = 0; i < 3; i++) begin
            assert (rcv_cnt[i] == next_seq[i])
                else note_fail($sformatf("input %0d count mismatch after delivery", i));
        end
        $display("test delivery done, errors %0d", errors);

        foreach (cap_seq[i]) cap_seq[i] = next_seq[i] + 60;
        valid_pct = 100;
        ready_pct = '{100, 100};
        repeat (10) step(); // warm up to steady state
        fair_on = 1'b1;
        repeat (30) step();
        fair_on = 1'b0;
        foreach (cap_seq[i]) cap_seq[i] = next_seq[i];
        wait_done(0, 200, "drain after fairness traffic");
        $display("test fairness done, errors %0d", errors);

        foreach (cap_seq[i]) cap_seq[i] = next_seq[i] + 30;
        foreach (via1_cnt[i]) via1_cnt[i] = 0;
        ready_pct = '{0, 100};
        wait_done(2, 1000, "drain of all inputs through output 1");
        for (int i = 0; i < 3; i++) begin
            assert (via1_cnt[i] > 0)
                else note_fail($sformatf("input %0d did not drain through output 1", i));
        end
        ready_pct[0] = 100;
        wait_done(0, 200, "release of held output 0 beats");
        for (int i = 0; i < 3; i++) begin
            assert (rcv_cnt[i] == next_seq[i])
                else note_fail($sformatf("input %0d count mismatch after stall", i));
        end
        $display("test stall_output_0 done, errors %0d", errors);

        $display("sent %0d received %0d errors %0d", total_sent(), total_rcv(), errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+include
hw/xbar_pkg.sv
hw/stream_slice.sv
hw/rr_grant.sv
hw/xbar_switch.sv
hw/xbar_top.sv
verification/tb_xbar_top.sv

// File: Makefile
SIM   := verilator
FLAGS := --binary --timing --assert -Wno-fatal
TOP   := tb_xbar_top
FLIST := list.f
BUILD := obj_dir
LOG   := sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	cat $(LOG)
	! grep -q "Finished with errors" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
